// File: axil_pkg.sv
package axil_pkg;

    // ==================================================
    // register map
    // ==================================================

    // byte offsets inside the register region
    localparam logic [9:0] addr_ctrl     = 10'h000;
    localparam logic [9:0] addr_item_num = 10'h004;
    localparam logic [9:0] addr_even     = 10'h008;

    // lowest of the two region bits, addr[11:10] must be zero to hit
    localparam int region_bits = 10;

    // only response ever returned
    localparam logic [1:0] resp_okay = 2'b00;

    // ==================================================
    // channel and register structs
    // ==================================================

    // write request latched from the aw and w channels
    typedef struct packed {
        logic [11:2] addr;
        logic [31:0] data;
    } axil_wreq_t;

    // control registers seen by the datapath
    // ctrl word layout: bit1 run, bit0 gen
    typedef struct packed {
        logic        run;
        logic        gen;
        logic [15:0] item_memory_num;
        logic        even;
    } ctrl_regs_t;

endpackage

// File: axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  logic [31:0]          S_AXI_AWADDR,
    input  logic                 S_AXI_AWVALID,
    output logic                 S_AXI_AWREADY,
    input  logic [31:0]          S_AXI_WDATA,
    input  logic [3:0]           S_AXI_WSTRB,
    input  logic                 S_AXI_WVALID,
    output logic                 S_AXI_WREADY,
    output logic [1:0]           S_AXI_BRESP,
    output logic                 S_AXI_BVALID,
    input  logic                 S_AXI_BREADY,
    input  logic [31:0]          S_AXI_ARADDR,
    input  logic                 S_AXI_ARVALID,
    output logic                 S_AXI_ARREADY,
    output logic [31:0]          S_AXI_RDATA,
    output logic [1:0]           S_AXI_RRESP,
    output logic                 S_AXI_RVALID,
    input  logic                 S_AXI_RREADY,
    input  logic                 gen_done,
    output axil_pkg::ctrl_regs_t regs
);

    // idle, got aw, got w, write response, read decode, read response
    typedef enum logic [2:0] {
        st_idle, st_aw, st_w, st_resp, st_ar1, st_ar2
    } state_t;

    state_t               state;
    axil_pkg::axil_wreq_t wreq;
    logic [3:0]           wstrb;
    logic [11:2]          raddr;
    logic                 wr_first;
    logic                 wr_hit;
    logic [9:0]           wr_off;
    logic [9:0]           rd_off;
    logic [31:0]          rd_word;

    // ==================================================
    // handshakes
    // ==================================================

    assign S_AXI_AWREADY = (state == st_idle) || (state == st_w);
    assign S_AXI_WREADY  = (state == st_idle) || (state == st_aw);
    // a pending write wins over a read
    assign S_AXI_ARREADY = (state == st_idle) && !S_AXI_AWVALID && !S_AXI_WVALID;
    assign S_AXI_BVALID  = (state == st_resp);
    assign S_AXI_RVALID  = (state == st_ar2);
    assign S_AXI_BRESP   = axil_pkg::resp_okay;
    assign S_AXI_RRESP   = axil_pkg::resp_okay;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state    <= st_idle;
            wr_first <= 1'b0;
        end else begin
            // one-cycle strobe on entry to the response state
            wr_first <= 1'b0;
            case (state)
                st_idle: begin
                    if (S_AXI_AWVALID && S_AXI_WVALID) begin
                        state    <= st_resp;
                        wr_first <= 1'b1;
                    end else if (S_AXI_AWVALID) begin
                        state <= st_aw;
                    end else if (S_AXI_WVALID) begin
                        state <= st_w;
                    end else if (S_AXI_ARVALID) begin
                        state <= st_ar1;
                    end
                end
                st_aw: begin
                    if (S_AXI_WVALID) begin
                        state    <= st_resp;
                        wr_first <= 1'b1;
                    end
                end
                st_w: begin
                    if (S_AXI_AWVALID) begin
                        state    <= st_resp;
                        wr_first <= 1'b1;
                    end
                end
                st_resp: if (S_AXI_BREADY) state <= st_idle;
                st_ar1:  state <= st_ar2;
                st_ar2:  if (S_AXI_RREADY) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // address and data latches, word address only
    always_ff @(posedge AXIS_ACLK) begin
        if (S_AXI_AWVALID && S_AXI_AWREADY) wreq.addr <= S_AXI_AWADDR[11:2];
        if (S_AXI_WVALID && S_AXI_WREADY) begin
            wreq.data <= S_AXI_WDATA;
            wstrb     <= S_AXI_WSTRB;
        end
        if (S_AXI_ARVALID && S_AXI_ARREADY) raddr <= S_AXI_ARADDR[11:2];
    end

    // ==================================================
    // register write
    // ==================================================

    assign wr_off = {wreq.addr[9:2], 2'b00};
    assign wr_hit = wr_first && (wreq.addr[axil_pkg::region_bits +: 2] == 2'b00);

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            regs <= '0;
        end else begin
            // self-clear, a write below on the same edge overrides it
            if (gen_done) regs.gen <= 1'b0;
            if (wr_hit) begin
                case (wr_off)
                    axil_pkg::addr_ctrl: begin
                        if (wstrb[0]) begin
                            regs.run <= wreq.data[1];
                            regs.gen <= wreq.data[0];
                        end
                    end
                    axil_pkg::addr_item_num: begin
                        if (wstrb[0]) regs.item_memory_num[7:0] <= wreq.data[7:0];
                        if (wstrb[1]) regs.item_memory_num[15:8] <= wreq.data[15:8];
                    end
                    axil_pkg::addr_even: if (wstrb[0]) regs.even <= wreq.data[0];
                    default: ;
                endcase
            end
        end
    end

    // ==================================================
    // register read
    // ==================================================

    assign rd_off = {raddr[9:2], 2'b00};

    always_comb begin
        rd_word = '0;
        // outside the region or unmapped reads as zero
        if (raddr[axil_pkg::region_bits +: 2] == 2'b00) begin
            case (rd_off)
                axil_pkg::addr_ctrl:     rd_word[1:0] = {regs.run, regs.gen};
                axil_pkg::addr_item_num: rd_word[15:0] = regs.item_memory_num;
                axil_pkg::addr_even:     rd_word[0] = regs.even;
                default: ;
            endcase
        end
    end

    // read data captured in the decode cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (state == st_ar1) S_AXI_RDATA <= rd_word;
    end

endmodule

// File: bundle_core.sv
`timescale 1ns/1ps

module bundle_core (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  axil_pkg::ctrl_regs_t regs,
    input  hdc_pkg::hv_t         seed,
    input  hdc_pkg::hv_t         lane,
    input  logic                 in_fire,
    input  logic                 clear,
    output hdc_pkg::hv_t         majority
);

    hdc_pkg::hv_t                 bound;
    logic [hdc_pkg::cnt_width-1:0] cnt [hdc_pkg::hv_dim];
    logic [hdc_pkg::cnt_width-1:0] beats;
    logic [hdc_pkg::cnt_width-1:0] half;

    // ==================================================
    // binding and counting
    // ==================================================

    // bind by xor with the seed hypervector
    assign bound = lane ^ seed;

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || clear) begin
            // clear wins, no beat is accepted during a flush
            beats <= '0;
            for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
                cnt[j] <= '0;
            end
        end else if (in_fire) begin
            beats <= beats + 1'b1;
            // one ones counter per bit position
            for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
                cnt[j] <= cnt[j] + {{(hdc_pkg::cnt_width-1){1'b0}}, bound[j]};
            end
        end
    end

    // ==================================================
    // majority threshold
    // ==================================================

    // half the beat count, rounded down
    assign half = beats >> 1;

    always_comb begin
        for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
            if (cnt[j] > half) begin
                majority[j] = 1'b1;
            end else if (({1'b0, cnt[j]} << 1) == {1'b0, beats}) begin
                // exact tie, only possible on an even beat count
                // even set: follow the seed bit, else zero
                majority[j] = regs.even ? seed[j] : 1'b0;
            end else begin
                majority[j] = 1'b0;
            end
        end
    end

endmodule

// File: bundle_stream_ctrl.sv
`timescale 1ns/1ps

module bundle_stream_ctrl (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  axil_pkg::ctrl_regs_t regs,
    input  logic                 S_AXIS_TVALID,
    input  logic                 S_AXIS_TLAST,
    output logic                 S_AXIS_TREADY,
    input  hdc_pkg::lanes_t      majorities,
    output logic                 in_fire,
    output logic                 clear,
    output hdc_pkg::lanes_t      M_AXIS_TDATA,
    output logic                 M_AXIS_TVALID,
    output logic                 M_AXIS_TLAST,
    input  logic                 M_AXIS_TREADY
);

    logic flush;

    // ==================================================
    // input side
    // ==================================================

    // stall input while a flush is pending or a result is offered
    assign S_AXIS_TREADY = regs.run && !flush && !M_AXIS_TVALID;
    assign in_fire       = S_AXIS_TVALID && S_AXIS_TREADY;

    // counters reset on the flush edge or while stopped
    assign clear = flush || !regs.run;

    // flush lands one edge after the last beat
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !regs.run) begin
            flush <= 1'b0;
        end else begin
            flush <= in_fire && S_AXIS_TLAST;
        end
    end

    // ==================================================
    // output beat
    // ==================================================

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !regs.run) begin
            M_AXIS_TVALID <= 1'b0;
        end else if (flush) begin
            M_AXIS_TVALID <= 1'b1;
        end else if (M_AXIS_TREADY) begin
            // beat taken
            M_AXIS_TVALID <= 1'b0;
        end
    end

    // majorities are still valid on the flush edge
    // data holds until the next flush
    always_ff @(posedge AXIS_ACLK) begin
        if (flush) M_AXIS_TDATA <= majorities;
    end

    // one output beat per packet
    assign M_AXIS_TLAST = M_AXIS_TVALID;

endmodule

// File: hdc_pkg.sv
package hdc_pkg;

    // ==================================================
    // sizes
    // ==================================================

    // one xorshift32 word is one item, so dim is 32
    localparam int hv_dim = 32;

    // one core per 32-bit lane
    localparam int num_cores = 4;
    localparam int stream_width = hv_dim * num_cores;

    // per-bit ones counters and the beat counter
    // packets are limited to 255 beats
    localparam int cnt_width = 8;

    // item index width, matches the item_memory_num register
    localparam int item_width = 16;

    // xorshift32 start state
    localparam logic [31:0] xs_seed = 32'd2463534242;

    // ==================================================
    // vector and beat types
    // ==================================================

    typedef logic [hv_dim-1:0] hv_t;

    // lane 0 sits in the low 32 bits of the stream
    typedef hv_t [num_cores-1:0] lanes_t;

    typedef struct packed {
        lanes_t data;
        logic   last;
    } in_beat_t;

endpackage

// File: hdc_top.sv
`timescale 1ns/1ps

module hdc_top (
    input  logic                               AXIS_ACLK,
    input  logic                               S_AXI_ARESETN,
    // axi-lite slave
    input  logic [31:0]                        S_AXI_AWADDR,
    input  logic                               S_AXI_AWVALID,
    output logic                               S_AXI_AWREADY,
    input  logic [31:0]                        S_AXI_WDATA,
    input  logic [3:0]                         S_AXI_WSTRB,
    input  logic                               S_AXI_WVALID,
    output logic                               S_AXI_WREADY,
    output logic [1:0]                         S_AXI_BRESP,
    output logic                               S_AXI_BVALID,
    input  logic                               S_AXI_BREADY,
    input  logic [31:0]                        S_AXI_ARADDR,
    input  logic                               S_AXI_ARVALID,
    output logic                               S_AXI_ARREADY,
    output logic [31:0]                        S_AXI_RDATA,
    output logic [1:0]                         S_AXI_RRESP,
    output logic                               S_AXI_RVALID,
    input  logic                               S_AXI_RREADY,
    // stream in, one lane per core
    input  logic [hdc_pkg::stream_width-1:0]   S_AXIS_TDATA,
    input  logic                               S_AXIS_TLAST,
    input  logic                               S_AXIS_TVALID,
    output logic                               S_AXIS_TREADY,
    // stream out, one beat per packet
    output logic [hdc_pkg::stream_width-1:0]   M_AXIS_TDATA,
    output logic                               M_AXIS_TLAST,
    output logic                               M_AXIS_TVALID,
    input  logic                               M_AXIS_TREADY
);

    axil_pkg::ctrl_regs_t regs;
    logic                 gen_done;
    hdc_pkg::hv_t         seed;
    hdc_pkg::in_beat_t    s_beat;
    hdc_pkg::lanes_t      majorities;
    hdc_pkg::lanes_t      m_data;
    logic                 in_fire;
    logic                 clear;

    assign s_beat.data  = S_AXIS_TDATA;
    assign s_beat.last  = S_AXIS_TLAST;
    assign M_AXIS_TDATA = m_data;

    // ==================================================
    // control and seed
    // ==================================================

    axil_regs u_regs (.*);

    item_gen u_gen (.*);

    // ==================================================
    // bundling cores
    // ==================================================

    for (genvar i = 0; i < hdc_pkg::num_cores; i++) begin : g_core
        bundle_core u_core (
            .AXIS_ACLK     (AXIS_ACLK),
            .S_AXI_ARESETN (S_AXI_ARESETN),
            .regs          (regs),
            .seed          (seed),
            .lane          (s_beat.data[i]),
            .in_fire       (in_fire),
            .clear         (clear),
            .majority      (majorities[i])
        );
    end

    bundle_stream_ctrl u_stream (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .regs          (regs),
        .S_AXIS_TVALID (S_AXIS_TVALID),
        .S_AXIS_TLAST  (s_beat.last),
        .S_AXIS_TREADY (S_AXIS_TREADY),
        .majorities    (majorities),
        .in_fire       (in_fire),
        .clear         (clear),
        .M_AXIS_TDATA  (m_data),
        .M_AXIS_TVALID (M_AXIS_TVALID),
        .M_AXIS_TLAST  (M_AXIS_TLAST),
        .M_AXIS_TREADY (M_AXIS_TREADY)
    );

endmodule

// File: item_gen.sv
`timescale 1ns/1ps

module item_gen (
    input  logic                 AXIS_ACLK,
    input  logic                 S_AXI_ARESETN,
    input  axil_pkg::ctrl_regs_t regs,
    output hdc_pkg::hv_t         seed,
    output logic                 gen_done
);

    logic [31:0]                  xs;
    logic [31:0]                  xs_nxt;
    logic [hdc_pkg::item_width-1:0] idx;
    logic                         hit;

    // ==================================================
    // xorshift32 step
    // ==================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // item idx is the next generator output
    assign xs_nxt = xorshift32(xs);

    // selected item reached, hold off once gen_done is out
    assign hit = regs.gen && !gen_done && (idx == regs.item_memory_num);

    // ==================================================
    // item memory walk
    // ==================================================

    // walk restarts whenever gen is low or a walk just finished
    // so a gen write on the clearing edge starts a fresh walk
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN || !regs.gen || gen_done) begin
            xs       <= hdc_pkg::xs_seed;
            idx      <= '0;
            gen_done <= 1'b0;
        end else begin
            xs       <= xs_nxt;
            idx      <= idx + 1'b1;
            // one-cycle pulse, clears gen in the register block
            gen_done <= hit;
        end
    end

    // seed capture
    // held across gen low, only the next hit replaces it
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            seed <= '0;
        end else if (hit) begin
            seed <= xs_nxt;
        end
    end

endmodule

// File: project.f
axil_pkg.sv
hdc_pkg.sv
axil_regs.sv
item_gen.sv
bundle_core.sv
bundle_stream_ctrl.sv
hdc_top.sv
tb_hdc_top.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the hdc encoder testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_hdc_top -f project.f

out=$(./obj_dir/Vtb_hdc_top)
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
    exit 0
fi
exit 1

// File: tb_hdc_top.sv
`timescale 1ns/1ps

module tb_hdc_top;

    // bounds for every wait, in cycles or polls
    localparam int wait_limit = 2000;
    localparam int poll_limit = 400;

    // one row per packet case
    typedef struct packed {
        logic [15:0] item_num;
        logic        even;
        logic [7:0]  beats;
        logic        stall;
        logic        reuse;
    } case_t;

    logic         AXIS_ACLK;
    logic         S_AXI_ARESETN;
    logic [31:0]  S_AXI_AWADDR;
    logic         S_AXI_AWVALID;
    logic         S_AXI_AWREADY;
    logic [31:0]  S_AXI_WDATA;
    logic [3:0]   S_AXI_WSTRB;
    logic         S_AXI_WVALID;
    logic         S_AXI_WREADY;
    logic [1:0]   S_AXI_BRESP;
    logic         S_AXI_BVALID;
    logic         S_AXI_BREADY;
    logic [31:0]  S_AXI_ARADDR;
    logic         S_AXI_ARVALID;
    logic         S_AXI_ARREADY;
    logic [31:0]  S_AXI_RDATA;
    logic [1:0]   S_AXI_RRESP;
    logic         S_AXI_RVALID;
    logic         S_AXI_RREADY;
    logic [127:0] S_AXIS_TDATA;
    logic         S_AXIS_TLAST;
    logic         S_AXIS_TVALID;
    logic         S_AXIS_TREADY;
    logic [127:0] M_AXIS_TDATA;
    logic         M_AXIS_TLAST;
    logic         M_AXIS_TVALID;
    logic         M_AXIS_TREADY;

    int              errors;
    int              checks;
    int              tests;
    logic [31:0]     lfsr;
    hdc_pkg::lanes_t pkt [256];
    case_t           cases [8];

    hdc_top dut0 (.*);

    initial begin
        AXIS_ACLK = 1'b0;
        forever #10 AXIS_ACLK = ~AXIS_ACLK;
    end

    // ==================================================
    // checking and random bits
    // ==================================================

    task automatic compare(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) $display("test %-16s ok", name);
        else $display("test %-16s failed with %0d errors", name, errors - err_before);
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic draw_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic draw_word(output logic [31:0] w);
        for (int b = 0; b < 32; b++) begin
            w[b] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================

    // item k is the (k+1)-th xorshift32 output
    function automatic logic [31:0] model_item(input int k);
        logic [31:0] x;
        x = hdc_pkg::xs_seed;
        for (int i = 0; i <= k; i++) begin
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
        end
        return x;
    endfunction

    // majority over n beats of lane data xor seed
    function automatic hdc_pkg::hv_t model_majority(input int lane, input int n,
                                                    input hdc_pkg::hv_t sd, input logic even);
        hdc_pkg::hv_t m;
        int           ones;
        for (int j = 0; j < hdc_pkg::hv_dim; j++) begin
            ones = 0;
            for (int k = 0; k < n; k++) begin
                ones += int'(pkt[k][lane][j] ^ sd[j]);
            end
            // tie only on even n
            if (2 * ones > n) m[j] = 1'b1;
            else if (2 * ones == n) m[j] = even & sd[j];
            else m[j] = 1'b0;
        end
        return m;
    endfunction

    // even n, second half is the first half xor a mask
    // masked bits then tie exactly
    task automatic build_packet(input int n);
        logic [31:0]     w;
        hdc_pkg::lanes_t mask;
        for (int i = 0; i < hdc_pkg::num_cores; i++) begin
            draw_word(w);
            mask[i] = w;
        end
        for (int k = 0; k < n; k++) begin
            if (n % 2 == 0 && k >= n / 2) begin
                pkt[k] = pkt[k - n / 2] ^ mask;
            end else begin
                for (int i = 0; i < hdc_pkg::num_cores; i++) begin
                    draw_word(w);
                    pkt[k][i] = w;
                end
            end
        end
    endtask

    // ==================================================
    // axi-lite tasks, entered and left 1 ns after an edge
    // ==================================================

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
        int   cycles;
        logic aw_take;
        logic w_take;
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        S_AXI_WSTRB   = 4'hf;
        S_AXI_AWVALID = 1'b1;
        S_AXI_WVALID  = 1'b1;
        cycles = 0;
        while (S_AXI_AWVALID || S_AXI_WVALID) begin
            @(negedge AXIS_ACLK);
            aw_take = S_AXI_AWVALID && S_AXI_AWREADY;
            w_take  = S_AXI_WVALID && S_AXI_WREADY;
            @(posedge AXIS_ACLK);
            #1;
            if (aw_take) S_AXI_AWVALID = 1'b0;
            if (w_take) S_AXI_WVALID = 1'b0;
            cycles++;
            if (cycles >= wait_limit) begin
                report_timeout("AWREADY and WREADY");
                S_AXI_AWVALID = 1'b0;
                S_AXI_WVALID  = 1'b0;
            end
        end
        S_AXI_BREADY = 1'b1;
        cycles = 0;
        @(negedge AXIS_ACLK);
        while (!S_AXI_BVALID && cycles < wait_limit) begin
            @(negedge AXIS_ACLK);
            cycles++;
        end
        if (!S_AXI_BVALID) report_timeout("BVALID");
        else compare("S_AXI_BRESP", S_AXI_BRESP, axil_pkg::resp_okay);
        @(posedge AXIS_ACLK);
        #1;
        S_AXI_BREADY = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        int cycles;
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        cycles = 0;
        @(negedge AXIS_ACLK);
        while (!S_AXI_ARREADY && cycles < wait_limit) begin
            @(negedge AXIS_ACLK);
            cycles++;
        end
        if (!S_AXI_ARREADY) report_timeout("ARREADY");
        @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        cycles = 0;
        @(negedge AXIS_ACLK);
        while (!S_AXI_RVALID && cycles < wait_limit) begin
            @(negedge AXIS_ACLK);
            cycles++;
        end
        data = S_AXI_RDATA;
        if (!S_AXI_RVALID) report_timeout("RVALID");
        else compare("S_AXI_RRESP", S_AXI_RRESP, axil_pkg::resp_okay);
        @(posedge AXIS_ACLK);
        #1;
        S_AXI_RREADY = 1'b0;
    endtask

    // gen=1 with run=0, then poll until gen self-clears
    task automatic run_gen();
        logic [31:0] rd;
        int          polls;
        axil_write(32'(axil_pkg::addr_ctrl), 32'h1);
        rd = 32'h1;
        polls = 0;
        while (rd[0] && polls < poll_limit) begin
            axil_read(32'(axil_pkg::addr_ctrl), rd);
            polls++;
        end
        if (rd[0]) report_timeout("gen bit to clear");
    endtask

    // ==================================================
    // stream tasks
    // ==================================================

    task automatic send_packet(input int n);
        int cycles;
        for (int k = 0; k < n; k++) begin
            S_AXIS_TDATA  = pkt[k];
            S_AXIS_TLAST  = (k == n - 1);
            S_AXIS_TVALID = 1'b1;
            cycles = 0;
            @(negedge AXIS_ACLK);
            while (!S_AXIS_TREADY && cycles < wait_limit) begin
                @(negedge AXIS_ACLK);
                cycles++;
            end
            if (!S_AXIS_TREADY) begin
                report_timeout("S_AXIS_TREADY");
                S_AXIS_TVALID = 1'b0;
                S_AXIS_TLAST  = 1'b0;
                return;
            end
            @(posedge AXIS_ACLK);
            #1;
        end
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
    endtask

    // waits for the one result beat, tready from the lfsr when stalling
    task automatic receive_beat(input logic stall, input hdc_pkg::lanes_t exp_beat);
        int              cycles;
        logic            rdy_bit;
        logic            seen;
        logic            taken;
        hdc_pkg::lanes_t held;
        seen  = 1'b0;
        taken = 1'b0;
        held  = '0;
        cycles = 0;
        while (!taken && cycles < wait_limit) begin
            if (stall) begin
                draw_bit(rdy_bit);
                M_AXIS_TREADY = rdy_bit;
            end else begin
                M_AXIS_TREADY = 1'b1;
            end
            @(negedge AXIS_ACLK);
            if (M_AXIS_TVALID) begin
                // offered data must not move until taken
                if (seen) compare("M_AXIS_TDATA held", M_AXIS_TDATA, held);
                else held = M_AXIS_TDATA;
                seen = 1'b1;
                compare("S_AXIS_TREADY while offered", S_AXIS_TREADY, 1'b0);
                compare("M_AXIS_TLAST", M_AXIS_TLAST, 1'b1);
                taken = M_AXIS_TREADY;
            end
            @(posedge AXIS_ACLK);
            #1;
            cycles++;
        end
        M_AXIS_TREADY = 1'b0;
        if (!taken) begin
            report_timeout("the output beat");
        end else begin
            for (int i = 0; i < hdc_pkg::num_cores; i++) begin
                compare($sformatf("M_AXIS_TDATA lane %0d", i), held[i], exp_beat[i]);
            end
            // exactly one beat per packet
            repeat (8) begin
                @(negedge AXIS_ACLK);
                compare("M_AXIS_TVALID after beat", M_AXIS_TVALID, 1'b0);
            end
            @(posedge AXIS_ACLK);
            #1;
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        int              first_err;
        logic [31:0]     rd;
        hdc_pkg::hv_t    seed;
        hdc_pkg::lanes_t exp_beat;
        errors = 0;
        checks = 0;
        tests  = 0;
        lfsr   = 32'd85556;
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WSTRB   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        S_AXIS_TDATA  = '0;
        S_AXIS_TLAST  = 1'b0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b0;
        // item, even, beats, stall, reuse previous data
        cases = '{
            '{16'd0,    1'b0, 8'd1,  1'b0, 1'b0},
            '{16'd3,    1'b0, 8'd5,  1'b0, 1'b0},
            '{16'd17,   1'b1, 8'd9,  1'b1, 1'b0},
            '{16'd99,   1'b1, 8'd8,  1'b0, 1'b0},
            '{16'd99,   1'b0, 8'd8,  1'b0, 1'b1},
            '{16'd250,  1'b1, 8'd2,  1'b1, 1'b0},
            '{16'd1023, 1'b0, 8'd31, 1'b1, 1'b0},
            '{16'd5,    1'b1, 8'd64, 1'b1, 1'b0}
        };
        repeat (10) @(posedge AXIS_ACLK);
        #1;
        S_AXI_ARESETN = 1'b1;

        // reset values and register access
        first_err = errors;
        @(negedge AXIS_ACLK);
        compare("S_AXIS_TREADY", S_AXIS_TREADY, 1'b0);
        compare("M_AXIS_TVALID", M_AXIS_TVALID, 1'b0);
        compare("S_AXI_BVALID", S_AXI_BVALID, 1'b0);
        compare("S_AXI_RVALID", S_AXI_RVALID, 1'b0);
        @(posedge AXIS_ACLK);
        #1;
        axil_read(32'h0, rd);
        compare("ctrl after reset", rd, 32'h0);
        axil_read(32'h4, rd);
        compare("item_memory_num after reset", rd, 32'h0);
        axil_read(32'h8, rd);
        compare("even after reset", rd, 32'h0);
        axil_write(32'h4, 32'h1234);
        axil_write(32'h8, 32'h1);
        axil_read(32'h4, rd);
        compare("item_memory_num", rd, 32'h1234);
        axil_read(32'h8, rd);
        compare("even", rd, 32'h1);
        axil_read(32'hc, rd);
        compare("unmapped 0x0c", rd, 32'h0);
        // bit 10 set, outside the register region
        axil_write(32'h404, 32'hbeef);
        axil_read(32'h4, rd);
        compare("item_memory_num after 0x404", rd, 32'h1234);
        axil_read(32'h404, rd);
        compare("read at 0x404", rd, 32'h0);
        finish_test("register access", first_err);

        for (int c = 0; c < 8; c++) begin
            first_err = errors;
            axil_write(32'(axil_pkg::addr_item_num), 32'(cases[c].item_num));
            axil_write(32'(axil_pkg::addr_even), 32'(cases[c].even));
            run_gen();
            axil_write(32'(axil_pkg::addr_ctrl), 32'h2);
            if (!cases[c].reuse) build_packet(int'(cases[c].beats));
            seed = model_item(int'(cases[c].item_num));
            for (int i = 0; i < hdc_pkg::num_cores; i++) begin
                exp_beat[i] = model_majority(i, int'(cases[c].beats), seed, cases[c].even);
            end
            send_packet(int'(cases[c].beats));
            receive_beat(cases[c].stall, exp_beat);
            finish_test($sformatf("packet %0d", c), first_err);
        end

        // stopped, input must stay blocked
        first_err = errors;
        axil_write(32'(axil_pkg::addr_ctrl), 32'h0);
        S_AXIS_TDATA  = pkt[0];
        S_AXIS_TLAST  = 1'b1;
        S_AXIS_TVALID = 1'b1;
        M_AXIS_TREADY = 1'b1;
        repeat (20) begin
            @(negedge AXIS_ACLK);
            compare("S_AXIS_TREADY with run=0", S_AXIS_TREADY, 1'b0);
            compare("M_AXIS_TVALID with run=0", M_AXIS_TVALID, 1'b0);
        end
        @(posedge AXIS_ACLK);
        #1;
        S_AXIS_TVALID = 1'b0;
        S_AXIS_TLAST  = 1'b0;
        M_AXIS_TREADY = 1'b0;
        finish_test("run off", first_err);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
